// ==== compile.f ====
+incdir+verif
hw/fpFormatPkg.sv
hw/fpOpPkg.sv
hw/fpClassify.sv
hw/fpRound.sv
hw/fpMultiply.sv
hw/fpMulUnit.sv
verif/fpMulTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run with Verilator, then look for the pass line in the output
verilator --binary --timing --assert -f compile.f --top-module fpMulTb -Mdir obj_dir \
    && ./obj_dir/VfpMulTb | tee /dev/stderr | grep -qx "PASS: all tests" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== verif/fpMulModel.svh ====
`ifndef FP_MUL_MODEL_SVH
`define FP_MUL_MODEL_SVH

// One-hot class of a word, zero in bit 0 up to quiet NaN in bit 5
function automatic logic [5:0] modelClass(logic [31:0] w);
        logic [5:0] cls;
        if (w[30:23] == 8'hFF) begin
                if (w[22:0] == 23'd0)
                        cls = 6'b001000;
                else
                        cls = w[22] ? 6'b100000 : 6'b010000;
        end else if (w[30:23] == 8'h00) begin
                cls = (w[22:0] == 23'd0) ? 6'b000001 : 6'b000010;
        end else begin
                cls = 6'b000100;
        end
        return cls;
endfunction

// Rounds the 23 bits under the leading bit, a carry runs on into the exponent field
function automatic logic [30:0] roundPack(logic sign, logic [47:0] sig, logic [7:0] expField,
                                          logic [2:0] rm);
        logic half;
        logic below;
        logic up;
        half  = sig[23];
        below = sig[22:0] != 23'd0;
        case (rm)
                3'd1: up = 1'b0;
                3'd2: up = sign & (half | below);
                3'd3: up = ~sign & (half | below);
                3'd4: up = half;
                default: up = half & (below | sig[24]);
        endcase
        return {expField, sig[46:24]} + {30'd0, up};
endfunction

// Expected product word
function automatic logic [31:0] mulModel(logic [31:0] a, logic [31:0] b, logic [2:0] rm);
        logic        sign;
        logic [5:0]  ca;
        logic [5:0]  cb;
        logic [47:0] prod;
        int          e;
        sign = a[31] ^ b[31];
        ca   = modelClass(a);
        cb   = modelClass(b);
        if (ca[5] || cb[5])
                return ca[5] ? a : b;
        if (ca[4] || cb[4])
                return ca[4] ? a : b;
        if (ca[3] || cb[3])
                return (ca[0] || cb[0]) ? {sign, 8'hFF, 1'b1, 22'd0} : {sign, 8'hFF, 23'd0};
        if (ca[0] || cb[0] || (ca[1] && cb[1]))
                return {sign, 31'd0};
        prod = {24'd0, a[30:23] != 8'd0, a[22:0]} * {24'd0, b[30:23] != 8'd0, b[22:0]};
        e    = ((a[30:23] == 8'd0) ? -126 : int'(a[30:23]) - 127) +
               ((b[30:23] == 8'd0) ? -126 : int'(b[30:23]) - 127);
        // Leading bit moves to bit 47 with one shift at most
        if (prod[47])
                e = e + 1;
        else
                prod = prod << 1;
        if (e < -149)
                return {sign, 31'd0};
        if (e > 127)
                return {sign, 8'hFF, 23'd0};
        if (e < -126)
                return {sign, roundPack(sign, prod >> (-126 - e), 8'd0, rm)};
        return {sign, roundPack(sign, prod, 8'(e + 127), rm)};
endfunction

`endif

// ==== verif/fpMulTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpMulTb import fpFormatPkg::*, fpOpPkg::*; ();

        localparam int CLK_PERIOD   = 8;
        localparam int RESET_CYCLES = 5;
        localparam int REQ_TOTAL    = 191;
        // Directed requests need a few cycles each to issue and drain
        localparam int TIMEOUT_NS   = (RESET_CYCLES + 6 * REQ_TOTAL + 50) * CLK_PERIOD;

        typedef logic [31:0] wordList_t [5];

        logic        clk;
        logic        rstN;
        logic        reqValid;
        mulReq_s     req;
        logic        resValid;
        mulRes_s     res;
        int          errors;
        int          checks;
        int          testsRun;
        logic [31:0] rngState;

        fpMulUnit #(
                .SIG_PROD_W(48)
        ) i_fpMulUnit (
                .clk_i     (clk),
                .rstN_i    (rstN),
                .reqValid_i(reqValid),
                .req_i     (req),
                .resValid_o(resValid),
                .res_o     (res)
        );

        `include "fpMulModel.svh"

        initial begin
                clk = 1'b0;
                forever #(CLK_PERIOD / 2) clk = ~clk;
        end

        initial begin
                #(TIMEOUT_NS);
                $display("Watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
                $display("FAIL: see errors above");
                $finish;
        end

        function automatic logic [31:0] nextRandom();
                logic [31:0] x;
                x = rngState;
                x = x ^ (x << 13);
                x = x ^ (x >> 17);
                x = x ^ (x << 5);
                rngState = x;
                return x;
        endfunction

        // Exponent field 64..191 keeps most products normal
        function automatic logic [31:0] randomNormal();
                logic [31:0] r;
                r = nextRandom();
                return {r[31], 8'd64 + {1'b0, r[29:23]}, r[22:0]};
        endfunction

        task automatic checkField(string name, logic [31:0] expected, logic [31:0] actual);
                checks++;
                assert (actual === expected)
                else begin
                        $display("Error: %0t ns %s expected %h got %h", $time, name, expected,
                                 actual);
                        errors++;
                end
        endtask

        task automatic reportTest(string name, int startErr);
                testsRun++;
                $display("Test %s finished with %0d errors", name, errors - startErr);
        endtask

        task automatic driveRequest(logic [31:0] a, logic [31:0] b, logic [2:0] rm);
                req.a.bits = a;
                req.b.bits = b;
                req.rm     = roundMode_e'(rm);
                reqValid   = 1'b1;
        endtask

        task automatic checkResult(logic [31:0] expWord);
                checkField("res_o.value", expWord, res.value.bits);
                checkField("res_o.cls", {26'd0, modelClass(expWord)}, {26'd0, res.cls});
        endtask

        // One request and a wait for its strobe
        task automatic runRequest(logic [31:0] a, logic [31:0] b, logic [2:0] rm);
                int waited;
                @(negedge clk);
                driveRequest(a, b, rm);
                @(negedge clk);
                reqValid = 1'b0;
                waited   = 0;
                while (!resValid && waited < 4) begin
                        @(negedge clk);
                        waited++;
                end
                assert (resValid)
                else begin
                        $display("No resValid_o strobe arrived for %h * %h", a, b);
                        errors++;
                end
                if (resValid)
                        checkResult(mulModel(a, b, rm));
        endtask

        task automatic runPairs(wordList_t as, wordList_t bs, int modes);
                for (int m = 0; m < modes; m++) begin
                        for (int i = 0; i < 5; i++)
                                runRequest(as[i], bs[i], 3'(m));
                end
        endtask

        task automatic testValidTiming();
                int startErr;
                startErr = errors;
                checkField("resValid_o", 32'd0, {31'd0, resValid});
                @(negedge clk);
                driveRequest(32'h40400000, 32'h40000000, 3'd0);
                @(negedge clk);
                reqValid = 1'b0;
                // Request sits in the operand stage
                checkField("resValid_o", 32'd0, {31'd0, resValid});
                @(negedge clk);
                assert (resValid)
                else begin
                        $display("resValid_o did not rise two cycles after the request");
                        errors++;
                end
                // 3.0 * 2.0
                checkField("res_o.value", 32'h40C00000, res.value.bits);
                checkField("res_o.cls", 32'h4, {26'd0, res.cls});
                @(negedge clk);
                checkField("resValid_o", 32'd0, {31'd0, resValid});
                reportTest("valid timing", startErr);
        endtask

        // Zero, subnormal, normal, infinity, sNaN, qNaN on both sides
        task automatic testSpecialCases();
                logic [31:0] lhs [6];
                logic [31:0] rhs [6];
                int          startErr;
                startErr = errors;
                lhs = '{32'h80000000, 32'h00000003, 32'hBFC00000, 32'hFF800000, 32'h7F800001,
                        32'h7FC00123};
                rhs = '{32'h00000000, 32'h80000005, 32'h40400000, 32'h7F800000, 32'hFF800002,
                        32'hFFC00456};
                foreach (lhs[i]) begin
                        foreach (rhs[j])
                                runRequest(lhs[i], rhs[j], 3'd0);
                end
                reportTest("special cases", startErr);
        endtask

        task automatic testExact();
                wordList_t as;
                wordList_t bs;
                int        startErr;
                startErr = errors;
                as = '{32'h40400000, 32'h3F000000, 32'hC0E00000, 32'h3A800000, 32'h3F800000};
                bs = '{32'h40A00000, 32'h41000000, 32'h40C00000, 32'h49800000, 32'h3F800000};
                runPairs(as, bs, 5);
                reportTest("exact products", startErr);
        endtask

        // Sticky only, exact ties, a negative tie and a carry into the exponent
        task automatic testRounding();
                wordList_t as;
                wordList_t bs;
                int        startErr;
                startErr = errors;
                as = '{32'h3F800001, 32'hBF800001, 32'h3F800800, 32'hBF800800, 32'h3FFFFFFE};
                bs = '{32'h3F800001, 32'h3F800001, 32'h3F800800, 32'h3F800800, 32'h3F800001};
                runPairs(as, bs, 8);
                reportTest("rounding modes", startErr);
        endtask

        task automatic testRangeEdges();
                wordList_t as;
                wordList_t bs;
                int        startErr;
                startErr = errors;
                as = '{32'h7F000000, 32'h00800000, 32'h00800000, 32'h80800003, 32'h3F7FFFFF};
                bs = '{32'h40000000, 32'h2F800000, 32'h3F400000, 32'h3F000000, 32'h00800000};
                runPairs(as, bs, 5);
                reportTest("range edges", startErr);
        endtask

        task automatic testBackToBack();
                logic [31:0] expQ [$];
                int          startErr;
                startErr = errors;
                fork
                        begin
                                logic [31:0] a;
                                logic [31:0] b;
                                logic [2:0]  rm;
                                for (int i = 0; i < 64; i++) begin
                                        @(negedge clk);
                                        a  = randomNormal();
                                        b  = randomNormal();
                                        rm = 3'(nextRandom() % 32'd5);
                                        driveRequest(a, b, rm);
                                        expQ.push_back(mulModel(a, b, rm));
                                end
                                @(negedge clk);
                                reqValid = 1'b0;
                        end
                        begin
                                int waited;
                                waited = 0;
                                @(negedge clk);
                                while (!resValid && waited < 4) begin
                                        @(negedge clk);
                                        waited++;
                                end
                                // Results must follow one per cycle
                                for (int k = 0; k < 64; k++) begin
                                        assert (resValid)
                                        else begin
                                                $display("resValid_o low at back-to-back result %0d",
                                                         k);
                                                errors++;
                                        end
                                        checkResult(expQ.pop_front());
                                        @(negedge clk);
                                end
                        end
                join
                reportTest("back-to-back random", startErr);
        endtask

        initial begin
                rngState = 32'd24797;
                errors   = 0;
                checks   = 0;
                testsRun = 0;
                rstN     = 1'b0;
                reqValid = 1'b0;
                req      = '0;
                repeat (RESET_CYCLES) @(posedge clk);
                @(negedge clk);
                rstN = 1'b1;
                testValidTiming();
                testSpecialCases();
                testExact();
                testRounding();
                testRangeEdges();
                testBackToBack();
                $display("%0d tests, %0d checks, %0d errors", testsRun, checks, errors);
                if (errors == 0) begin
                        $display("PASS: all tests");
                end else begin
                        $display("FAIL: see errors above");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== hw/fpMulUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpMulUnit import fpFormatPkg::*, fpOpPkg::*; #(
        parameter int SIG_PROD_W = 48
) (
        input  logic    clk_i,
        input  logic    rstN_i,
        input  logic    reqValid_i,
        input  mulReq_s req_i,
        output logic    resValid_o,
        output mulRes_s res_o
);

        fpOperand_s opA;
        fpOperand_s opB;
        fpOperand_s opAReg;
        fpOperand_s opBReg;
        roundMode_e rmReg;
        logic       stageValid;
        mulRes_s    mulRes;

        fpClassify i_classifyA (
                .op_i     (req_i.a),
                .operand_o(opA)
        );

        fpClassify i_classifyB (
                .op_i     (req_i.b),
                .operand_o(opB)
        );

        // Valid bits of both stages
        always_ff @(posedge clk_i) begin
                if (!rstN_i) begin
                        stageValid <= 1'b0;
                        resValid_o <= 1'b0;
                end else begin
                        stageValid <= reqValid_i;
                        resValid_o <= stageValid;
                end
        end

        // Operand stage, holds when idle
        always_ff @(posedge clk_i) begin
                if (reqValid_i) begin
                        opAReg <= opA;
                        opBReg <= opB;
                        rmReg  <= req_i.rm;
                end
        end

        fpMultiply #(
                .SIG_PROD_W(SIG_PROD_W)
        ) i_fpMultiply (
                .rs1_i(opAReg),
                .rs2_i(opBReg),
                .rm_i (rmReg),
                .res_o(mulRes)
        );

        // Result stage
        always_ff @(posedge clk_i) begin
                if (stageValid) begin
                        res_o <= mulRes;
                end
        end

        // Every request comes out exactly two edges later, and nothing else does
        assert property (@(posedge clk_i) disable iff (!rstN_i)
                ##2 (resValid_o == $past(reqValid_i, 2)))
        else $error("fpMulUnit: resValid_o does not follow reqValid_i by two cycles");

endmodule

`default_nettype wire

// ==== hw/fpMultiply.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpMultiply import fpFormatPkg::*, fpOpPkg::*; #(
        parameter int SIG_PROD_W = 48
) (
        input  fpOperand_s rs1_i,
        input  fpOperand_s rs2_i,
        input  roundMode_e rm_i,
        output mulRes_s    res_o
);

        logic                   outSign;
        logic [SIG_PROD_W-1:0]  sigProd;
        logic signed [10:0]     expSum;
        logic [SIG_PROD_W-1:0]  sigNorm;
        logic signed [10:0]     expNorm;
        logic [SIG_PROD_W-1:0]  sigRnd;
        logic [7:0]             expBiased;
        logic [22:0]            fracRnd;
        logic [7:0]             expRnd;
        fpWord_u                outWord;

        assign outSign = rs1_i.word.f.sign ^ rs2_i.word.f.sign;
        assign sigProd = rs1_i.sig * rs2_i.sig;
        assign expSum  = $signed({rs1_i.exp[9], rs1_i.exp}) + $signed({rs2_i.exp[9], rs2_i.exp});

        // One shift at most puts the leading bit into the top
        always_comb begin
                if (sigProd[SIG_PROD_W-1]) begin
                        sigNorm = sigProd;
                        expNorm = expSum + 11'sd1;
                end else begin
                        sigNorm = sigProd << 1;
                        expNorm = expSum;
                end
        end

        // Below EMIN the significand is denormalized and the rounder sees a zero leading bit
        always_comb begin
                if (expNorm < EMIN) begin
                        sigRnd    = sigNorm >> (EMIN - expNorm);
                        expBiased = 8'd0;
                end else begin
                        sigRnd    = sigNorm;
                        expBiased = 8'(expNorm + EXP_BIAS);
                end
        end

        fpRound #(
                .nInt(SIG_PROD_W)
        ) i_fpRound (
                .sign_i(outSign),
                .sig_i (sigRnd),
                .exp_i (expBiased),
                .rm_i  (rm_i),
                .frac_o(fracRnd),
                .exp_o (expRnd)
        );

        always_comb begin
                outWord = '0;

                // NaNs pass through unchanged with quiet before signalling and rs1 first
                if (rs1_i.cls[CLASS_BIT_QNAN] || rs2_i.cls[CLASS_BIT_QNAN]) begin
                        outWord = rs1_i.cls[CLASS_BIT_QNAN] ? rs1_i.word : rs2_i.word;
                end else if (rs1_i.cls[CLASS_BIT_SNAN] || rs2_i.cls[CLASS_BIT_SNAN]) begin
                        outWord = rs1_i.cls[CLASS_BIT_SNAN] ? rs1_i.word : rs2_i.word;
                end else if (rs1_i.cls[CLASS_BIT_INF] || rs2_i.cls[CLASS_BIT_INF]) begin
                        // Inf x 0 is invalid and gives the canonical qNaN with the product sign
                        if (rs1_i.cls[CLASS_BIT_ZERO] || rs2_i.cls[CLASS_BIT_ZERO]) begin
                                outWord.bits = {outSign, 8'hFF, 1'b1, 22'd0};
                        end else begin
                                outWord.bits = {outSign, 8'hFF, 23'd0};
                        end
                end else if (rs1_i.cls[CLASS_BIT_ZERO] || rs2_i.cls[CLASS_BIT_ZERO] ||
                             (rs1_i.cls[CLASS_BIT_SUB] && rs2_i.cls[CLASS_BIT_SUB])) begin
                        // Sub x sub lies far below range and is flushed
                        outWord.bits = {outSign, 31'd0};
                end else if (expNorm < SUBNORM_MIN) begin
                        outWord.bits = {outSign, 31'd0};
                end else if (expNorm > EXP_BIAS) begin
                        outWord.bits = {outSign, 8'hFF, 23'd0};
                end else begin
                        // Subnormal and normal results both come out of the rounder
                        outWord.f.sign = outSign;
                        outWord.f.exp  = expRnd;
                        outWord.f.frac = fracRnd;
                end
        end

        // Class follows the packed word, so a rounded-up subnormal reads as normal
        always_comb begin
                res_o.value = outWord;
                res_o.cls   = classOf(outWord);
                assert final ($onehot(res_o.cls))
                else $error("fpMultiply: result class %b is not one-hot", res_o.cls);
        end

endmodule

`default_nettype wire

// ==== hw/fpRound.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpRound import fpOpPkg::*; #(
        parameter int nInt = 48
) (
        input  logic            sign_i,
        input  logic [nInt-1:0] sig_i,
        input  logic [7:0]      exp_i,
        input  roundMode_e      rm_i,
        output logic [22:0]     frac_o,
        output logic [7:0]      exp_o
);

        logic [22:0] kept;
        logic        guard;
        logic        sticky;
        logic        inexact;
        logic        roundUp;

        // Fraction sits just below the leading bit
        assign kept    = sig_i[nInt-2 -: 23];
        assign guard   = sig_i[nInt-25];
        assign sticky  = |sig_i[nInt-26:0];
        assign inexact = guard | sticky;

        always_comb begin
                case (rm_i)
                        RTZ: begin
                                roundUp = 1'b0;
                        end
                        RDN: begin
                                roundUp = inexact & sign_i;
                        end
                        RUP: begin
                                roundUp = inexact & ~sign_i;
                        end
                        RMM: begin
                                roundUp = guard;
                        end
                        // RNE, also the reserved encodings
                        default: begin
                                roundUp = guard & (sticky | kept[0]);
                        end
                endcase
        end

        // Carry out of the fraction bumps the exponent
        // (subnormal to exponent 1, exponent 254 to infinity)
        assign {exp_o, frac_o} = {exp_i, kept} + 31'(roundUp);

endmodule

`default_nettype wire

// ==== hw/fpClassify.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpClassify import fpFormatPkg::*; (
        input  fpWord_u    op_i,
        output fpOperand_s operand_o
);

        fpClass_t cls;

        assign cls = classOf(op_i);

        always_comb begin
                operand_o.word = op_i;
                operand_o.cls  = cls;
                // Zero and subnormal share the minimum exponent, no hidden bit
                if (op_i.f.exp == 8'h00) begin
                        operand_o.exp = 10'(EMIN);
                        operand_o.sig = {1'b0, op_i.f.frac};
                end else begin
                        operand_o.exp = 10'($signed({2'b00, op_i.f.exp}) - EXP_BIAS);
                        operand_o.sig = {1'b1, op_i.f.frac};
                end
        end

        // Class must be exactly one of the six
        always_comb begin
                assert final ($onehot(cls))
                else $error("fpClassify: class %b of word %h is not one-hot", cls, op_i.bits);
        end

endmodule

`default_nettype wire

// ==== hw/fpOpPkg.sv ====
`default_nettype none

package fpOpPkg;

        import fpFormatPkg::*;

        // RISC-V rounding modes, 5 to 7 fall back to RNE in the rounder
        typedef enum logic [2:0] {
                RNE = 3'd0,
                RTZ = 3'd1,
                RDN = 3'd2,
                RUP = 3'd3,
                RMM = 3'd4
        } roundMode_e;

        // One multiply request
        typedef struct packed {
                fpWord_u    a;
                fpWord_u    b;
                roundMode_e rm;
        } mulReq_s;

        // Product word and its class
        typedef struct packed {
                fpWord_u  value;
                fpClass_t cls;
        } mulRes_s;

endpackage

`default_nettype wire

// ==== hw/fpFormatPkg.sv ====
`default_nettype none

package fpFormatPkg;

        // IEEE single-precision field view
        typedef struct packed {
                logic        sign;
                logic [7:0]  exp;
                logic [22:0] frac;
        } fpFields_s;

        // One operand word read raw or by field
        typedef union packed {
                logic [31:0] bits;
                fpFields_s   f;
        } fpWord_u;

        // One-hot operand class
        typedef logic [5:0] fpClass_t;

        localparam int CLASS_BIT_ZERO = 0;
        localparam int CLASS_BIT_SUB  = 1;
        localparam int CLASS_BIT_NORM = 2;
        localparam int CLASS_BIT_INF  = 3;
        localparam int CLASS_BIT_SNAN = 4;
        localparam int CLASS_BIT_QNAN = 5;

        localparam fpClass_t CLASS_ZERO = 6'b000001;
        localparam fpClass_t CLASS_SUB  = 6'b000010;
        localparam fpClass_t CLASS_NORM = 6'b000100;
        localparam fpClass_t CLASS_INF  = 6'b001000;
        localparam fpClass_t CLASS_SNAN = 6'b010000;
        localparam fpClass_t CLASS_QNAN = 6'b100000;

        localparam int EXP_BIAS    = 127;
        localparam int EMIN        = -126;
        localparam int SUBNORM_MIN = -149;

        // Unpacked operand as the multiplier sees it
        typedef struct packed {
                fpWord_u           word;
                logic signed [9:0] exp;
                logic [23:0]       sig;
                fpClass_t          cls;
        } fpOperand_s;

        // Class of a packed word, each bit decoded from the fields on its own
        // The top fraction bit marks a quiet NaN
        function automatic fpClass_t classOf(fpWord_u w);
                fpClass_t cls;
                logic     expOnes;
                logic     expZero;
                logic     fracZero;
                expOnes  = (w.f.exp == 8'hFF);
                expZero  = (w.f.exp == 8'h00);
                fracZero = (w.f.frac == 23'd0);
                cls[CLASS_BIT_ZERO] = expZero & fracZero;
                cls[CLASS_BIT_SUB]  = expZero & ~fracZero;
                cls[CLASS_BIT_NORM] = ~expZero & ~expOnes;
                cls[CLASS_BIT_INF]  = expOnes & fracZero;
                cls[CLASS_BIT_SNAN] = expOnes & ~fracZero & ~w.f.frac[22];
                cls[CLASS_BIT_QNAN] = expOnes & w.f.frac[22];
                return cls;
        endfunction

endpackage

`default_nettype wire
